// File: logic/dataRam.sv
module dataRam #(
    parameter int ramAddrWidth = 10
) (
    input  logic                clk,
    input  mipsMemPkg::ramReq_t ramReq,
    output mipsMemPkg::word_t   ramRdata
);
    import mipsMemPkg::*;

    word_t                   mem [2**ramAddrWidth];
    logic [ramAddrWidth-1:0] wordAddr;

    // byte address to word index
    assign wordAddr = ramReq.addr[ramAddrWidth+1:2];

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (ramReq.byteEn[i]) begin
                mem[wordAddr][8*i +: 8] <= ramReq.writeData[8*i +: 8];
            end
        end
        // read register holds when no load is presented
        if (ramReq.readEn) begin
            ramRdata <= mem[wordAddr];
        end
    end

endmodule

// File: logic/execMemReg.sv
module execMemReg (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  mipsMemPkg::execData_t execIn,
    output mipsMemPkg::execData_t memEntry
);
    import mipsMemPkg::*;

    execData_t nopEntry;

    // all-zero entry, op field decodes as NOP
    always_comb begin
        nopEntry = '0;
        nopEntry.op = NOP;
    end

    // flush takes priority over stall
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            memEntry <= nopEntry;
        end else if (!stall) begin
            memEntry <= execIn;
        end
    end

endmodule

// File: logic/loadAlign.sv
module loadAlign (
    input  mipsMemPkg::memData_t wbRaw,
    input  mipsMemPkg::word_t    ramRdata,
    output mipsMemPkg::memData_t wbOut
);
    import mipsMemPkg::*;

    logic [15:0] halfSel;
    logic [7:0]  byteSel;

    // lane choice from the address bits kept in aluOut
    assign halfSel = wbRaw.aluOut[1] ? ramRdata[31:16] : ramRdata[15:0];
    assign byteSel = ramRdata[{wbRaw.aluOut[1:0], 3'b000} +: 8];

    always_comb begin
        wbOut = wbRaw;
        case (wbRaw.op)
            LW: begin
                wbOut.readData = ramRdata;
            end
            LH: begin
                wbOut.readData = {{16{halfSel[15]}}, halfSel};
            end
            LHU: begin
                wbOut.readData = {16'h0000, halfSel};
            end
            LB: begin
                wbOut.readData = {{24{byteSel[7]}}, byteSel};
            end
            LBU: begin
                wbOut.readData = {24'h000000, byteSel};
            end
            // not a load
            default: begin
                wbOut.readData = '0;
            end
        endcase
    end

endmodule

// File: logic/memSubsystem.sv
module memSubsystem #(
    parameter int ramAddrWidth = 10
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall,
    input  logic                    flush,
    input  mipsMemPkg::execData_t   execIn,
    input  logic [5:0]              extInt,
    input  logic [7:0]              causeIp,
    input  logic [7:0]              statusIm,
    output mipsMemPkg::memData_t    wbOut,
    output mipsMemPkg::exceptInfo_t exceptOut,
    output logic                    eretPulse
);
    import mipsMemPkg::*;

    execData_t memEntry;
    ramReq_t   ramReq;
    memData_t  stageOut;
    memData_t  wbRaw;
    word_t     ramRdata;

    execMemReg inReg (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .execIn   (execIn),
        .memEntry (memEntry)
    );

    memoryStage stage (
        .memEntry  (memEntry),
        .stall     (stall),
        .extInt    (extInt),
        .causeIp   (causeIp),
        .statusIm  (statusIm),
        .ramReq    (ramReq),
        .stageOut  (stageOut),
        .exceptOut (exceptOut),
        .eretPulse (eretPulse)
    );

    dataRam #(
        .ramAddrWidth (ramAddrWidth)
    ) ram (
        .clk      (clk),
        .ramReq   (ramReq),
        .ramRdata (ramRdata)
    );

    // writeback side, realigned with the RAM read data
    memWbReg outReg (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .stageOut (stageOut),
        .wbRaw    (wbRaw)
    );

    loadAlign loadExt (
        .wbRaw    (wbRaw),
        .ramRdata (ramRdata),
        .wbOut    (wbOut)
    );

endmodule

// File: logic/memWbReg.sv
module memWbReg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  mipsMemPkg::memData_t stageOut,
    output mipsMemPkg::memData_t wbRaw
);
    import mipsMemPkg::*;

    memData_t nopResult;

    // cleared result, decodes as NOP
    always_comb begin
        nopResult = '0;
        nopResult.op = NOP;
    end

    // captured at the same edge as the RAM read register,
    // so the fields line up with ramRdata one cycle later
    always_ff @(posedge clk) begin
        if (reset) begin
            wbRaw <= nopResult;
        end else if (!stall) begin
            wbRaw <= stageOut;
        end
    end

endmodule

// File: logic/memoryStage.sv
module memoryStage (
    input  mipsMemPkg::execData_t   memEntry,
    input  logic                    stall,
    input  logic [5:0]              extInt,
    input  logic [7:0]              causeIp,
    input  logic [7:0]              statusIm,
    output mipsMemPkg::ramReq_t     ramReq,
    output mipsMemPkg::memData_t    stageOut,
    output mipsMemPkg::exceptInfo_t exceptOut,
    output logic                    eretPulse
);
    import mipsMemPkg::*;

    decodedOp_t op;
    word_t      addr;
    logic       dataAddrError;
    logic       syscallHit;
    logic       breakHit;
    logic       anyExcept;
    logic       isLoad;
    byteEn_t    alignedEn;
    word_t      laneData;

    assign op   = memEntry.op;
    assign addr = memEntry.aluOut;

    // word accesses need both low bits clear, halfwords only bit 0
    always_comb begin
        case (op)
            LW, SW:      dataAddrError = (addr[1:0] != 2'b00);
            LH, LHU, SH: dataAddrError = addr[0];
            default:     dataAddrError = 1'b0;
        endcase
    end

    assign syscallHit = (op == SYSCALL);
    assign breakHit   = (op == BREAK);
    assign eretPulse  = (op == ERET);

    // anything that must keep this entry from touching memory
    assign anyExcept = memEntry.fetchAddrError | memEntry.reservedInstr | memEntry.overflow |
                       dataAddrError;

    assign isLoad = (op == LW) || (op == LH) || (op == LHU) || (op == LB) || (op == LBU);

    storeAlign laneSteer (
        .op        (op),
        .addrLow   (addr[1:0]),
        .storeData (memEntry.writeData),
        .byteEn    (alignedEn),
        .laneData  (laneData)
    );

    // RAM request, writes dropped under stall or on a fault
    assign ramReq.addr      = addr;
    assign ramReq.byteEn    = (stall || anyExcept) ? '0 : alignedEn;
    assign ramReq.writeData = laneData;
    assign ramReq.readEn    = isLoad && !stall;

    // readData is filled in after the RAM, on the writeback side
    assign stageOut.op       = op;
    assign stageOut.pcPlus4  = memEntry.pcPlus4;
    assign stageOut.aluOut   = addr;
    assign stageOut.readData = '0;
    assign stageOut.writeReg = memEntry.writeReg;
    assign stageOut.hi       = memEntry.hi;
    assign stageOut.lo       = memEntry.lo;

    assign exceptOut.fetchAddrError = memEntry.fetchAddrError;
    assign exceptOut.reservedInstr  = memEntry.reservedInstr;
    assign exceptOut.overflow       = memEntry.overflow;
    assign exceptOut.dataAddrError  = dataAddrError;
    assign exceptOut.syscall        = syscallHit;
    assign exceptOut.breakpoint     = breakHit;
    assign exceptOut.inDelaySlot    = memEntry.inDelaySlot;
    assign exceptOut.pc             = memEntry.pcPlus4 - 32'd4;
    assign exceptOut.badVaddr       = addr;

    // hardware lines sit at IP7..IP2, software bits come from cause
    assign exceptOut.interruptPending = ({extInt, 2'b00} | causeIp) & statusIm;

endmodule

// File: logic/mipsMemPkg.sv
package mipsMemPkg;

    // basic data and address word
    typedef logic [31:0] word_t;

    // destination register number
    typedef logic [4:0] regAddr_t;

    // one bit per byte lane, little-endian
    typedef logic [3:0] byteEn_t;

    // NOP must stay at zero so a cleared entry decodes as NOP
    typedef enum logic [3:0] {
        NOP     = 4'd0,
        ALU     = 4'd1,
        LW      = 4'd2,
        LH      = 4'd3,
        LHU     = 4'd4,
        LB      = 4'd5,
        LBU     = 4'd6,
        SW      = 4'd7,
        SH      = 4'd8,
        SB      = 4'd9,
        SYSCALL = 4'd10,
        BREAK   = 4'd11,
        ERET    = 4'd12
    } decodedOp_t;

    // result of the execute stage
    typedef struct packed {
        decodedOp_t op;
        word_t      pcPlus4;
        word_t      aluOut;
        word_t      writeData;
        regAddr_t   writeReg;
        word_t      hi;
        word_t      lo;
        logic       inDelaySlot;
        // flags raised in fetch, decode and execute
        logic       fetchAddrError;
        logic       reservedInstr;
        logic       overflow;
    } execData_t;

    // result handed on to writeback
    typedef struct packed {
        decodedOp_t op;
        word_t      pcPlus4;
        word_t      aluOut;
        word_t      readData;
        regAddr_t   writeReg;
        word_t      hi;
        word_t      lo;
    } memData_t;

    // request to the data RAM, addr is a byte address
    typedef struct packed {
        word_t   addr;
        byteEn_t byteEn;
        word_t   writeData;
        logic    readEn;
    } ramReq_t;

    // exception report towards cp0
    typedef struct packed {
        logic       fetchAddrError;
        logic       reservedInstr;
        logic       overflow;
        logic       dataAddrError;
        logic       syscall;
        logic       breakpoint;
        logic       inDelaySlot;
        word_t      pc;
        word_t      badVaddr;
        logic [7:0] interruptPending;
    } exceptInfo_t;

endpackage

// File: logic/storeAlign.sv
module storeAlign (
    input  mipsMemPkg::decodedOp_t op,
    input  logic [1:0]             addrLow,
    input  mipsMemPkg::word_t      storeData,
    output mipsMemPkg::byteEn_t    byteEn,
    output mipsMemPkg::word_t      laneData
);
    import mipsMemPkg::*;

    // data is replicated so every lane carries it,
    // the enables pick which lanes really get written
    always_comb begin
        case (op)
            SW: begin
                byteEn   = 4'b1111;
                laneData = storeData;
            end
            SH: begin
                laneData = {2{storeData[15:0]}};
                // upper half when address bit 1 is set
                if (addrLow[1]) begin
                    byteEn = 4'b1100;
                end else begin
                    byteEn = 4'b0011;
                end
            end
            SB: begin
                laneData = {4{storeData[7:0]}};
                byteEn   = 4'b0001 << addrLow;
            end
            default: begin
                byteEn   = 4'b0000;
                laneData = storeData;
            end
        endcase
    end

endmodule

// File: memSubsystem.f
logic/mipsMemPkg.sv
logic/storeAlign.sv
logic/execMemReg.sv
logic/memoryStage.sv
logic/dataRam.sv
logic/loadAlign.sv
logic/memWbReg.sv
logic/memSubsystem.sv
verif/memSubsystemTb.sv

// File: runSim.sh
#!/bin/sh
# compile with Verilator, run, then look for the fail message in the log

verilator --binary --timing --top-module memSubsystemTb -f memSubsystem.f -o memSubsystemSim \
    || { echo "build failed"; exit 1; }

./obj_dir/memSubsystemSim > sim.log 2>&1 || echo "simulator exited with an error status"

cat sim.log

grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// File: verif/memSubsystemTb.sv
module memSubsystemTb;
    timeunit 1ns;
    timeprecision 100ps;

    import mipsMemPkg::*;

    localparam int initCount    = 16;
    localparam int pairCount    = 150;
    localparam int singleCount  = 100;
    localparam int misCount     = 20;
    localparam int specialCount = 30;
    localparam int aluCount     = 30;
    localparam int stallCount   = 60;
    localparam int drainCount   = 4;
    // one entry per driven cycle
    localparam int numIssued = initCount + 2 * pairCount + singleCount + 2 * misCount +
                               specialCount + aluCount + stallCount + drainCount;

    logic        clk = 1'b0;
    logic        reset;
    logic        stall;
    logic        flush;
    execData_t   execIn;
    logic [5:0]  extInt;
    logic [7:0]  causeIp;
    logic [7:0]  statusIm;
    memData_t    wbOut;
    exceptInfo_t exceptOut;
    logic        eretPulse;

    integer seed = 32'hd9d8_f6f4;

    // expected contents of memEntry and wbOut
    execData_t modelMem;
    memData_t  modelWb;
    word_t     shadow [1024];

    decodedOp_t storeOps [4] = '{SW, SH, SB, SW};
    decodedOp_t loadOps [8]  = '{LW, LH, LHU, LB, LBU, LHU, LB, LBU};

    memSubsystem dut0 (
        .clk       (clk),
        .reset     (reset),
        .stall     (stall),
        .flush     (flush),
        .execIn    (execIn),
        .extInt    (extInt),
        .causeIp   (causeIp),
        .statusIm  (statusIm),
        .wbOut     (wbOut),
        .exceptOut (exceptOut),
        .eretPulse (eretPulse)
    );

    always #4 clk = ~clk;

    function automatic word_t randWord();
        randWord = $random(seed);
    endfunction

    function automatic decodedOp_t randomMemOp();
        word_t w;
        w = randWord();
        return w[3] ? storeOps[w[1:0]] : loadOps[w[2:0]];
    endfunction

    // byte address inside the 16-word test window at 0x100
    function automatic word_t windowAddr();
        word_t w;
        w = randWord();
        return {23'h0, 1'b1, 2'b00, w[5:0]};
    endfunction

    function automatic word_t alignFor(decodedOp_t op, word_t a);
        case (op)
            LW, SW:      a[1:0] = 2'b00;
            LH, LHU, SH: a[0] = 1'b0;
            default:     a = a;
        endcase
        return a;
    endfunction

    function automatic execData_t makeEntry(decodedOp_t op, word_t addr);
        execData_t e;
        word_t     w;
        e = '0;
        w = randWord();
        e.op = op;
        e.pcPlus4 = {w[31:2], 2'b00};
        e.aluOut = addr;
        e.writeData = randWord();
        e.writeReg = w[6:2];
        e.hi = randWord();
        e.lo = randWord();
        return e;
    endfunction

    // readData as loadAlign should produce it from the shadow word
    function automatic word_t expectLoad(decodedOp_t op, word_t addr, word_t mem [1024]);
        word_t       w;
        logic [15:0] h;
        logic [7:0]  b;
        w = mem[addr[11:2]];
        h = addr[1] ? w[31:16] : w[15:0];
        case (addr[1:0])
            2'd0:    b = w[7:0];
            2'd1:    b = w[15:8];
            2'd2:    b = w[23:16];
            default: b = w[31:24];
        endcase
        case (op)
            LW:      return w;
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'h0000, h};
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'h000000, b};
            default: return '0;
        endcase
    endfunction

    function automatic exceptInfo_t expectExcept(execData_t e, logic [5:0] ei,
                                                 logic [7:0] ci, logic [7:0] si);
        exceptInfo_t x;
        x = '0;
        x.fetchAddrError = e.fetchAddrError;
        x.reservedInstr = e.reservedInstr;
        x.overflow = e.overflow;
        case (e.op)
            LW, SW:      x.dataAddrError = (e.aluOut[1:0] != 2'b00);
            LH, LHU, SH: x.dataAddrError = e.aluOut[0];
            default:     x.dataAddrError = 1'b0;
        endcase
        x.syscall = (e.op == SYSCALL);
        x.breakpoint = (e.op == BREAK);
        x.inDelaySlot = e.inDelaySlot;
        x.pc = e.pcPlus4 - 32'd4;
        x.badVaddr = e.aluOut;
        x.interruptPending = ({ei, 2'b00} | ci) & si;
        return x;
    endfunction

    // little-endian lane update of the shadow word
    task automatic applyStore(input decodedOp_t op, input word_t addr, input word_t data);
        logic [9:0] idx;
        idx = addr[11:2];
        case (op)
            SW: shadow[idx] = data;
            SH: begin
                if (addr[1]) begin
                    shadow[idx][31:16] = data[15:0];
                end else begin
                    shadow[idx][15:0] = data[15:0];
                end
            end
            SB: begin
                case (addr[1:0])
                    2'd0:    shadow[idx][7:0] = data[7:0];
                    2'd1:    shadow[idx][15:8] = data[7:0];
                    2'd2:    shadow[idx][23:16] = data[7:0];
                    default: shadow[idx][31:24] = data[7:0];
                endcase
            end
            default: shadow[idx] = shadow[idx];
        endcase
    endtask

    task automatic checkWb(input memData_t actual, input memData_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: wbOut readData %h aluOut %h, expected readData %h aluOut %h",
                     $time, actual.readData, actual.aluOut, expected.readData, expected.aluOut);
            $display("Some tests failed");
            $fatal(1, "writeback result mismatch");
        end
    endtask

    task automatic checkExcept(input exceptInfo_t actual, input exceptInfo_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: exceptOut %h, expected %h", $time, actual, expected);
            $display("Some tests failed");
            $fatal(1, "exception report mismatch");
        end
    endtask

    task automatic checkBit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("** Error at %0t: %s is %b, expected %b", $time, what, actual, expected);
            $display("Some tests failed");
            $fatal(1, "single bit mismatch");
        end
    endtask

    // one entry per cycle, interrupt lines change with it
    task automatic issue(input execData_t e, input logic st, input logic fl);
        word_t w;
        @(posedge clk);
        #1;
        w = randWord();
        execIn = e;
        stall = st;
        flush = fl;
        extInt = w[5:0];
        causeIp = w[15:8];
        statusIm = w[23:16];
    endtask

    // pipeline model, stepped with the DUT edges
    always @(posedge clk) begin
        exceptInfo_t x;
        if (reset) begin
            modelMem = '0;
            modelWb = '0;
        end else begin
            if (!stall) begin
                x = expectExcept(modelMem, 6'd0, 8'd0, 8'd0);
                modelWb.op = modelMem.op;
                modelWb.pcPlus4 = modelMem.pcPlus4;
                modelWb.aluOut = modelMem.aluOut;
                modelWb.writeReg = modelMem.writeReg;
                modelWb.hi = modelMem.hi;
                modelWb.lo = modelMem.lo;
                modelWb.readData = expectLoad(modelMem.op, modelMem.aluOut, shadow);
                // faulting stores leave memory alone
                if (!(x.fetchAddrError || x.reservedInstr || x.overflow || x.dataAddrError)) begin
                    applyStore(modelMem.op, modelMem.aluOut, modelMem.writeData);
                end
            end
            if (flush) begin
                modelMem = '0;
            end else if (!stall) begin
                modelMem = execIn;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            checkWb(wbOut, modelWb);
            checkExcept(exceptOut, expectExcept(modelMem, extInt, causeIp, statusIm));
            checkBit(eretPulse, modelMem.op == ERET, "eretPulse");
        end
    end

    initial begin
        #((numIssued + 50) * 8);
        $display("simulation timed out before the tests completed");
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        word_t      a;
        word_t      w;
        decodedOp_t op;
        execData_t  e;
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        execIn = '0;
        extInt = '0;
        causeIp = '0;
        statusIm = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // fill the window so every load sees known data
        for (int i = 0; i < initCount; i++) begin
            issue(makeEntry(SW, 32'h0000_0100 + i * 4), 1'b0, 1'b0);
        end

        // store then load within the same word, back to back
        for (int i = 0; i < pairCount; i++) begin
            w = randWord();
            op = storeOps[w[1:0]];
            a = alignFor(op, windowAddr());
            issue(makeEntry(op, a), 1'b0, 1'b0);
            w = randWord();
            op = loadOps[w[2:0]];
            issue(makeEntry(op, alignFor(op, {a[31:2], w[4:3]})), 1'b0, 1'b0);
        end

        for (int i = 0; i < singleCount; i++) begin
            op = randomMemOp();
            issue(makeEntry(op, alignFor(op, windowAddr())), 1'b0, 1'b0);
        end

        // misaligned access, then a word load to see memory untouched
        for (int i = 0; i < misCount; i++) begin
            w = randWord();
            case (w[2:0])
                3'd0, 3'd5: op = LW;
                3'd1, 3'd6: op = SW;
                3'd2:       op = LH;
                3'd3:       op = LHU;
                default:    op = SH;
            endcase
            a = windowAddr();
            if (op == LW || op == SW) begin
                a[1:0] = (w[4:3] == 2'b00) ? 2'b01 : w[4:3];
            end else begin
                a[0] = 1'b1;
            end
            issue(makeEntry(op, a), 1'b0, 1'b0);
            issue(makeEntry(LW, {a[31:2], 2'b00}), 1'b0, 1'b0);
        end

        // syscall, break, eret and alu with carried flags
        for (int i = 0; i < specialCount; i++) begin
            w = randWord();
            case (w[1:0])
                2'd0:    op = SYSCALL;
                2'd1:    op = BREAK;
                2'd2:    op = ERET;
                default: op = ALU;
            endcase
            e = makeEntry(op, randWord());
            e.fetchAddrError = w[4];
            e.reservedInstr = w[5];
            e.overflow = w[6];
            e.inDelaySlot = w[7];
            issue(e, 1'b0, 1'b0);
        end

        for (int i = 0; i < aluCount; i++) begin
            issue(makeEntry(ALU, randWord()), 1'b0, 1'b0);
        end

        // random stall and flush on memory traffic
        for (int i = 0; i < stallCount; i++) begin
            op = randomMemOp();
            w = randWord();
            issue(makeEntry(op, alignFor(op, windowAddr())), w[1:0] == 2'b00, w[4:2] == 3'b000);
        end

        for (int i = 0; i < drainCount; i++) begin
            issue(makeEntry(NOP, '0), 1'b0, 1'b0);
        end

        @(negedge clk);
        #1;
        $display("All tests passed");
        $finish;
    end

endmodule
